// File: verilog.f
src/fetch_pkg.sv
src/fetch_push_if.sv
src/fetch_pop_if.sv
src/fetch_pc_gen.sv
src/fetch_queue.sv
src/fetch_issue.sv
src/fetch_unit.sv
tb/tb_fetch_unit.sv

// File: Makefile
# Verilator build and run for the fetch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_unit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit import fetch_pkg::*; ();

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] SEED         = 32'h1aa8;
    localparam inst_t       MEM_PATTERN  = 32'ha5c3_0f96; // memory word = address ^ pattern

    // cycle budget of each test
    localparam int SEQ_CYCLES   = 200;
    localparam int BP_CYCLES    = 1600;
    localparam int JUMP_CYCLES  = 200;
    localparam int REDIR_CYCLES = 200;
    localparam int PEND_CYCLES  = 400;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SEQ_CYCLES + BP_CYCLES + JUMP_CYCLES +
                                  REDIR_CYCLES + PEND_CYCLES;

    localparam addr_t  JUMP_TARGET  = 32'h6000_1000;
    localparam addr_t  REDIR_TARGET = 32'h6000_2000;
    localparam order_t REDIR_ORDER  = 64'h0000_0001_0000_0100;
    localparam addr_t  PEND_TARGET  = 32'h6000_4000;

    logic   clk = 1'b0;
    logic   rst;
    logic   i_imem_resp  = 1'b0;
    inst_t  i_imem_rdata = '0;
    addr_t  o_imem_addr;
    logic   i_jump;
    addr_t  i_jump_pc;
    logic   i_redirect;
    addr_t  i_redirect_pc;
    order_t i_redirect_order;
    logic   i_stall;
    logic   o_inst_valid;
    inst_t  o_inst;
    addr_t  o_inst_pc;
    addr_t  o_inst_next_pc;
    order_t o_inst_order;

    logic [31:0] rng = SEED;
    int          mem_wait = 0;   // idle cycles left before the memory answers

    // inputs as seen at the last rising edge
    logic   rst_q   = 1'b1;
    logic   stall_q = 1'b0;
    logic   resp_q  = 1'b0;
    int     mem_wait_q = 0;
    logic   jump_q  = 1'b0;
    addr_t  jump_pc_q;
    logic   redir_q = 1'b0;
    addr_t  redir_pc_q;
    order_t redir_ord_q;

    // reference model of the next pc and order at the decode port
    addr_t  exp_pc      = RESET_PC;
    order_t exp_order   = '0;
    int     issue_count = 0;
    int     check_count = 0;
    int     err_count   = 0;

    fetch_unit i_dut (
        .clk              (clk),
        .rst              (rst),
        .i_imem_resp      (i_imem_resp),
        .i_imem_rdata     (i_imem_rdata),
        .o_imem_addr      (o_imem_addr),
        .i_jump           (i_jump),
        .i_jump_pc        (i_jump_pc),
        .i_redirect       (i_redirect),
        .i_redirect_pc    (i_redirect_pc),
        .i_redirect_order (i_redirect_order),
        .i_stall          (i_stall),
        .o_inst_valid     (o_inst_valid),
        .o_inst           (o_inst),
        .o_inst_pc        (o_inst_pc),
        .o_inst_next_pc   (o_inst_next_pc),
        .o_inst_order     (o_inst_order)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_order(input string name, input order_t got, input order_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // memory model answers the held address after 1 to 3 cycles
    always @(negedge clk) begin
        if (rst_q) begin
            i_imem_resp = 1'b0;
            mem_wait    = 0;
        end else begin
            if (i_imem_resp) begin
                rng      = xorshift32(rng);
                mem_wait = rng % 3;
            end else if (mem_wait != 0) begin
                mem_wait = mem_wait - 1;
            end
            i_imem_resp = (mem_wait == 0);
            if (i_imem_resp) begin
                i_imem_rdata = o_imem_addr ^ MEM_PATTERN;
            end
        end
    end

    always @(posedge clk) begin
        rst_q       <= rst;
        stall_q     <= i_stall;
        resp_q      <= i_imem_resp;
        mem_wait_q  <= mem_wait;
        jump_q      <= i_jump;
        jump_pc_q   <= i_jump_pc;
        redir_q     <= i_redirect;
        redir_pc_q  <= i_redirect_pc;
        redir_ord_q <= i_redirect_order;
    end

    // a valid output after an unstalled edge is a new issue
    always @(negedge clk) begin
        if (!rst_q && !stall_q && o_inst_valid === 1'b1) begin
            check_addr("o_inst_pc", o_inst_pc, exp_pc);
            check_inst("o_inst", o_inst, exp_pc ^ MEM_PATTERN);
            check_addr("o_inst_next_pc", o_inst_next_pc, exp_pc + INST_BYTES);
            check_order("o_inst_order", o_inst_order, exp_order);
            exp_pc      = exp_pc + INST_BYTES;
            exp_order   = exp_order + 64'd1;
            issue_count <= issue_count + 1;
        end
        if (redir_q) begin
            exp_pc    = redir_pc_q;
            exp_order = redir_ord_q + 64'd1; // counter restored from commit
        end else if (jump_q) begin
            exp_pc = jump_pc_q;
        end
    end

    task automatic wait_issues(input int n, input int limit, input string what);
        int start;
        int cycles;
        start  = issue_count;
        cycles = 0;
        while (issue_count - start < n && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (issue_count - start < n) begin
            err_count++;
            $display("timeout at %0t: only %0d of %0d instructions issued (%s)",
                     $time, issue_count - start, n, what);
        end
    endtask

    task automatic reset_dut();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        check_addr("o_imem_addr", o_imem_addr, RESET_PC);
        check_valid("o_inst_valid", o_inst_valid, 1'b0);
        rst = 1'b0;
    endtask

    task automatic sequential_fetch();
        wait_issues(24, SEQ_CYCLES, "sequential fetch");
    endtask

    task automatic stall_backpressure();
        int     resp_cnt;
        int     stable_cnt;
        int     cycles;
        addr_t  last_addr;
        addr_t  held_pc;
        order_t held_order;
        logic   held_valid;
        @(negedge clk);
        i_stall    = 1'b1;
        held_valid = o_inst_valid;
        held_pc    = o_inst_pc;
        held_order = o_inst_order;
        last_addr  = o_imem_addr;
        resp_cnt   = 0;
        stable_cnt = 0;
        cycles     = 0;
        // run until the queue is full and the fetch address has stopped
        while ((resp_cnt <= QUEUE_DEPTH || stable_cnt < 8) && cycles < BP_CYCLES / 2) begin
            @(negedge clk);
            cycles++;
            if (resp_q) begin
                resp_cnt++;
            end
            stable_cnt = (o_imem_addr == last_addr) ? stable_cnt + 1 : 0;
            last_addr  = o_imem_addr;
            check_valid("o_inst_valid", o_inst_valid, held_valid);
            check_addr("o_inst_pc", o_inst_pc, held_pc);
            check_order("o_inst_order", o_inst_order, held_order);
        end
        if (stable_cnt < 8) begin
            err_count++;
            $display("fetch address still moving at %0t while stalled", $time);
        end
        // queue holds QUEUE_DEPTH words starting at the next expected pc
        check_addr("o_imem_addr", o_imem_addr, exp_pc + addr_t'(QUEUE_DEPTH) * INST_BYTES);
        i_stall = 1'b0;
        wait_issues(QUEUE_DEPTH + 8, BP_CYCLES / 2, "drain after stall");
    endtask

    task automatic jump_to_target();
        @(negedge clk);
        i_jump    = 1'b1;
        i_jump_pc = JUMP_TARGET;
        @(negedge clk);
        i_jump = 1'b0;
        wait_issues(8, JUMP_CYCLES, "issue after jump");
    endtask

    task automatic mispredict_restore();
        @(negedge clk);
        i_redirect       = 1'b1;
        i_redirect_pc    = REDIR_TARGET;
        i_redirect_order = REDIR_ORDER;
        @(negedge clk);
        i_redirect = 1'b0;
        wait_issues(8, REDIR_CYCLES, "issue after mispredict");
    endtask

    task automatic redirect_while_pending();
        int    cycles;
        addr_t old_addr;
        cycles = 0;
        @(negedge clk);
        // wait until the memory stays idle over the next edge
        while ((resp_q || mem_wait_q < 2) && cycles < PEND_CYCLES / 2) begin
            @(negedge clk);
            cycles++;
        end
        if (resp_q || mem_wait_q < 2) begin
            err_count++;
            $display("no pending memory response found by %0t", $time);
        end
        old_addr  = o_imem_addr;
        i_jump    = 1'b1;
        i_jump_pc = PEND_TARGET;
        @(negedge clk);
        i_jump = 1'b0;
        check_addr("o_imem_addr", o_imem_addr, old_addr);
        cycles = 0;
        while (o_imem_addr == old_addr && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        check_addr("o_imem_addr", o_imem_addr, PEND_TARGET); // stale word dropped
        wait_issues(6, PEND_CYCLES / 2, "issue after pending redirect");
    endtask

    initial begin
        rst              = 1'b1;
        i_jump           = 1'b0;
        i_jump_pc        = '0;
        i_redirect       = 1'b0;
        i_redirect_pc    = '0;
        i_redirect_order = '0;
        i_stall          = 1'b0;
        reset_dut();
        sequential_fetch();
        stall_backpressure();
        jump_to_target();
        mispredict_restore();
        redirect_while_pending();
        repeat (4) @(negedge clk);
        $display("%0d checks, %0d errors, %0d instructions issued",
                 check_count, err_count, issue_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", TOTAL_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // instruction memory
    input  logic   i_imem_resp,
    input  inst_t  i_imem_rdata,
    output addr_t  o_imem_addr,

    // redirects from decode and commit
    input  logic   i_jump,
    input  addr_t  i_jump_pc,
    input  logic   i_redirect,
    input  addr_t  i_redirect_pc,
    input  order_t i_redirect_order,

    // to decode
    input  logic   i_stall,
    output logic   o_inst_valid,
    output inst_t  o_inst,
    output addr_t  o_inst_pc,
    output addr_t  o_inst_next_pc,
    output order_t o_inst_order
);

    logic flush;
    logic restore;

    fetch_push_if push_if ();
    fetch_pop_if  pop_if ();

    fetch_pc_gen u_pc_gen (
        .clk           (clk),
        .rst           (rst),
        .i_imem_resp   (i_imem_resp),
        .i_imem_rdata  (i_imem_rdata),
        .i_jump        (i_jump),
        .i_jump_pc     (i_jump_pc),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_imem_addr   (o_imem_addr),
        .o_flush       (flush),
        .o_restore     (restore),
        .push          (push_if.pcgen)
    );

    fetch_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .i_flush (flush),
        .push    (push_if.queue),
        .pop     (pop_if.queue)
    );

    fetch_issue u_issue (
        .clk             (clk),
        .rst             (rst),
        .i_stall         (i_stall),
        .i_flush         (flush),
        .i_restore       (restore),
        .i_restore_order (i_redirect_order),
        .pop             (pop_if.issue),
        .o_inst_valid    (o_inst_valid),
        .o_inst          (o_inst),
        .o_inst_pc       (o_inst_pc),
        .o_inst_next_pc  (o_inst_next_pc),
        .o_inst_order    (o_inst_order)
    );

endmodule

// File: src/fetch_issue.sv
`timescale 1ns/1ps

module fetch_issue import fetch_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   i_stall,
    input  logic   i_flush,
    input  logic   i_restore,
    input  order_t i_restore_order,
    fetch_pop_if.issue pop,
    output logic   o_inst_valid,
    output inst_t  o_inst,
    output addr_t  o_inst_pc,
    output addr_t  o_inst_next_pc,
    output order_t o_inst_order
);

    order_t order_cnt; // order given to the next popped instruction
    logic   do_pop;

    always_comb begin
        do_pop  = !i_stall && !i_flush && !pop.empty;
        pop.pop = do_pop;
    end

    // valid bit and order counter
    always_ff @(posedge clk) begin
        if (rst) begin
            o_inst_valid <= 1'b0;
            order_cnt    <= '0;
        end else if (i_restore) begin
            // mispredict kills the output even under stall
            o_inst_valid <= 1'b0;
            order_cnt    <= i_restore_order + 64'd1;
        end else if (do_pop) begin
            o_inst_valid <= 1'b1;
            order_cnt    <= order_cnt + 64'd1;
        end else if (!i_stall) begin
            o_inst_valid <= 1'b0; // bubble
        end
    end

    // payload only loads on a pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            o_inst         <= pop.inst;
            o_inst_pc      <= pop.pc;
            o_inst_next_pc <= pop.pc + INST_BYTES; // fall-through
            o_inst_order   <= order_cnt;
        end
    end

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic i_flush,
    fetch_push_if.queue push,
    fetch_pop_if.queue  pop
);

    inst_t inst_mem [QUEUE_DEPTH];
    addr_t pc_mem   [QUEUE_DEPTH];

    qptr_t wr_ptr;
    qptr_t rd_ptr;
    logic  do_write;
    logic  do_read;

    always_comb begin
        do_write = push.push && !i_flush; // a push in a flush cycle is dropped
        do_read  = pop.pop && !i_flush;
    end

    // instruction and pc storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            inst_mem[wr_ptr[QPTR_W-2:0]] <= push.inst;
            pc_mem[wr_ptr[QPTR_W-2:0]]   <= push.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // full when the index matches and the wrap bits differ
    always_comb begin
        push.full = (wr_ptr[QPTR_W-1] != rd_ptr[QPTR_W-1]) &&
                    (wr_ptr[QPTR_W-2:0] == rd_ptr[QPTR_W-2:0]);
        pop.empty = (wr_ptr == rd_ptr);
    end

    // head entry read straight from storage
    always_comb begin
        pop.inst = inst_mem[rd_ptr[QPTR_W-2:0]];
        pop.pc   = pc_mem[rd_ptr[QPTR_W-2:0]];
    end

endmodule

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_imem_resp,
    input  inst_t i_imem_rdata,
    input  logic  i_jump,
    input  addr_t i_jump_pc,
    input  logic  i_redirect,
    input  addr_t i_redirect_pc,
    output addr_t o_imem_addr,
    output logic  o_flush,
    output logic  o_restore,
    fetch_push_if.pcgen push
);

    addr_t fetch_addr;   // address currently presented to memory
    addr_t pc_next;      // where to go after the current response
    logic  discard;      // response in flight is stale
    logic  redirect_any;
    addr_t target;
    logic  accept;

    always_comb begin
        redirect_any = i_jump || i_redirect;
        // mispredict beats jump
        target       = i_redirect ? i_redirect_pc : i_jump_pc;
        // memory repeats a response the full queue cannot take
        accept       = i_imem_resp && !push.full;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_addr <= RESET_PC;
            pc_next    <= RESET_PC + INST_BYTES;
            discard    <= 1'b0;
        end else if (redirect_any) begin
            if (i_imem_resp) begin
                // old path response is dropped and the target fetched now
                fetch_addr <= target;
                pc_next    <= target + INST_BYTES;
                discard    <= 1'b0;
            end else begin
                // hold address until the pending response shows up
                pc_next <= target;
                discard <= 1'b1;
            end
        end else if (accept) begin
            fetch_addr <= pc_next;
            pc_next    <= pc_next + INST_BYTES;
            discard    <= 1'b0; // stale word consumed if flag was set
        end
    end

    // queue write only for live responses on the current path
    always_comb begin
        push.push = accept && !discard && !redirect_any;
        push.inst = i_imem_rdata;
        push.pc   = fetch_addr;
    end

    always_comb begin
        o_imem_addr = fetch_addr;
        o_flush     = redirect_any;
        o_restore   = i_redirect; // order counter restore on mispredict only
    end

endmodule

// File: src/fetch_pop_if.sv
`timescale 1ns/1ps

// queue head as seen by the issue stage
interface fetch_pop_if import fetch_pkg::*; ();

    logic  empty; // nothing to issue
    inst_t inst;  // head instruction
    addr_t pc;    // head pc
    logic  pop;   // remove head at this edge

    modport queue (
        output empty,
        output inst,
        output pc,
        input  pop
    );

    modport issue (
        input  empty,
        input  inst,
        input  pc,
        output pop
    );

endinterface

// File: src/fetch_push_if.sv
`timescale 1ns/1ps

// one fetched word on its way from the pc generator into the queue
interface fetch_push_if import fetch_pkg::*; ();

    logic  push;  // write strobe
    inst_t inst;  // instruction from memory
    addr_t pc;    // address it was fetched from
    logic  full;  // queue has no free slot

    modport pcgen (
        output push,
        output inst,
        output pc,
        input  full
    );

    modport queue (
        input  push,
        input  inst,
        input  pc,
        output full
    );

endinterface

// File: src/fetch_pkg.sv
package fetch_pkg;

    // widths that carry a meaning
    typedef logic [31:0] addr_t;  // byte address of one instruction word
    typedef logic [31:0] inst_t;  // raw RV32I instruction
    typedef logic [63:0] order_t; // serial number of an issued instruction

    // fetch constants
    localparam addr_t RESET_PC   = 32'h6000_0000;
    localparam addr_t INST_BYTES = 32'd4;

    // fetch queue sizing
    localparam int QUEUE_DEPTH = 64;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH) + 1; // index plus wrap bit

    typedef logic [QPTR_W-1:0] qptr_t;

endpackage
